// File: files.f
capturePkg.sv
controlPkg.sv
triggerTransDetection.sv
analyzerControlFsm.sv
sampleGen.sv
logCap.sv
captureBuffer.sv
logCapSystem.sv
logCapTb.sv

// File: runSim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module logCapTb \
    -f files.f -o logCapSim \
    || { echo "Verilator build failed"; exit 1; }
simOutput=$(./obj_dir/logCapSim)
echo "$simOutput"
echo "$simOutput" | grep -qx "ALL CHECKS PASSED" && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: logCapTb.sv
`timescale 1ns/1ps
`default_nettype none

module logCapTb;

    logic                                   clk;
    logic                                   reset;
    logic [capturePkg::sampleWidth-1:0]     sampleData;
    logic [capturePkg::sampleWidth-1:0]     desiredPattern;
    logic [capturePkg::sampleWidth-1:0]     activeChannels;
    logic [capturePkg::sampleWidth-1:0]     dontCareChannels;
    logic [capturePkg::edgeSelWidth-1:0]    edgeChannel;
    logic                                   edgeType;
    logic                                   patternTriggerEnable;
    logic                                   edgeTriggerEnable;
    logic [capturePkg::countWidth-1:0]      maxSampleCount;
    logic [capturePkg::countWidth-1:0]      preTriggerSampleCount;
    logic                                   start;
    logic                                   abort;
    logic [controlPkg::statusWidth-1:0]     status;
    logic [capturePkg::bufferAddrWidth-1:0] readIndex;
    logic [capturePkg::packetWidth-1:0]     readData;
    logic [capturePkg::bufferAddrWidth:0]   storedCount;

    logic [31:0]                        lfsrState;
    int                                 errorCount;
    int                                 timeoutCount;
    logic [capturePkg::packetWidth-1:0] modelPackets[$]; // Expected packets in oldest-first order.
    logic [capturePkg::sampleWidth-1:0] loggedLast;
    logic [capturePkg::sampleWidth-1:0] loggedBeforeLast;
    int                                 runCycle;
    bit                                 runOpen;

    logCapSystem logCapSystem_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reference model. The DUT sees each driven sample one edge late, hence the two-deep log.
    always @(posedge clk) begin
        if (reset) begin
            modelPackets.delete();
            runCycle = 0;
            runOpen = 1'b0;
        end else begin
            if (start && status[controlPkg::statusIdleBit]) begin
                modelPackets.delete(); // A new capture empties the buffer.
            end
            if (status[controlPkg::statusPreBit] || status[controlPkg::statusPostBit]) begin
                if (!runOpen || loggedLast != loggedBeforeLast) begin
                    modelPackets.push_back({runCycle[capturePkg::stampWidth-1:0], loggedLast});
                end
                runCycle++;
                runOpen = 1'b1;
            end else begin
                runCycle = 0;
                runOpen = 1'b0;
            end
        end
        loggedBeforeLast = loggedLast;
        loggedLast = sampleData;
    end

    function automatic logic lfsrBit();
        logic feedback;
        feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], feedback};
        return feedback;
    endfunction

    function automatic logic [capturePkg::sampleWidth-1:0] randomBits(input int count);
        logic [capturePkg::sampleWidth-1:0] value;
        int i;
        value = '0;
        for (i = 0; i < count; i++) begin
            value = {value[capturePkg::sampleWidth-2:0], lfsrBit()};
        end
        return value;
    endfunction

    function automatic logic [controlPkg::statusWidth-1:0] statusWord(input int bitPos);
        return controlPkg::statusWidth'(1) << bitPos;
    endfunction

    task automatic expectTrue(input bit ok, input string what);
        assert (ok) else begin
            $display("CHECK FAILED at %0t ns: %s", $time, what);
            errorCount++;
        end
    endtask

    task automatic checkStatus(input int bitPos, input string what);
        @(negedge clk);
        expectTrue(status == statusWord(bitPos),
                   $sformatf("%s: status %b, expected only bit %0d", what, status, bitPos));
    endtask

    task automatic waitForStatus(input int bitPos, input string what);
        int guard;
        for (guard = 0; guard < 5000; guard++) begin
            @(negedge clk);
            if (status[bitPos]) begin
                return;
            end
        end
        $display("Timeout: %s, status bit %0d never went high", what, bitPos);
        timeoutCount++;
    endtask

    task automatic holdSample(input logic [capturePkg::sampleWidth-1:0] value, input int cycles);
        int i;
        for (i = 0; i < cycles; i++) begin
            @(posedge clk);
            sampleData <= value;
        end
    endtask

    task automatic pulseStart();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic pulseAbort();
        @(posedge clk);
        abort <= 1'b1;
        @(posedge clk);
        abort <= 1'b0;
    endtask

    task automatic startCapture(input string what);
        pulseStart();
        waitForStatus(controlPkg::statusPreBit, what);
    endtask

    task automatic measurePostTrigger(input int expected, input string what);
        int cycles;
        int guard;
        waitForStatus(controlPkg::statusPostBit, what);
        cycles = 1;
        for (guard = 0; guard < 5000; guard++) begin
            @(negedge clk);
            if (!status[controlPkg::statusPostBit]) break;
            cycles++;
        end
        if (guard == 5000) begin
            $display("Timeout: %s, post-trigger never ended", what);
            timeoutCount++;
        end
        expectTrue(cycles == expected,
                   $sformatf("%s: post-trigger lasted %0d cycles, expected %0d", what, cycles,
                             expected));
        expectTrue(status == statusWord(controlPkg::statusIdleBit), {what, ": not idle after"});
    endtask

    // New random value every 2 to 5 cycles until the capture ends.
    task automatic driveRandomUntilIdle(input string what);
        logic [capturePkg::sampleWidth-1:0] value;
        int holdLeft;
        int cycle;
        holdLeft = 0;
        value = sampleData;
        for (cycle = 0; cycle < 5000; cycle++) begin
            @(posedge clk);
            if (holdLeft == 0) begin
                value = randomBits(16);
                holdLeft = 2 + int'(randomBits(2));
            end
            holdLeft--;
            sampleData <= value;
            @(negedge clk);
            if (status[controlPkg::statusIdleBit]) begin
                return;
            end
        end
        $display("Timeout: %s never returned to idle", what);
        timeoutCount++;
    endtask

    task automatic checkReadout(input string what);
        logic [capturePkg::packetWidth-1:0] expected;
        logic [capturePkg::stampWidth-1:0]  firstGot;
        logic [capturePkg::stampWidth-1:0]  firstExpected;
        logic [capturePkg::stampWidth-1:0]  gotDelta;
        logic [capturePkg::stampWidth-1:0]  expectedDelta;
        int modelSize;
        int expectedCount;
        int i;
        repeat (2) @(negedge clk); // The last packet lands one edge after the run ends.
        modelSize = modelPackets.size();
        expectedCount = (modelSize > capturePkg::bufferDepth) ? capturePkg::bufferDepth : modelSize;
        expectTrue(int'(storedCount) == expectedCount,
                   $sformatf("%s: storedCount %0d, expected %0d", what, storedCount,
                             expectedCount));
        firstGot = '0;
        firstExpected = '0;
        for (i = 0; i < expectedCount; i++) begin
            expected = modelPackets[modelSize - expectedCount + i];
            @(posedge clk);
            readIndex <= capturePkg::bufferAddrWidth'(i);
            @(posedge clk);
            @(negedge clk);
            if (i == 0) begin
                firstGot = readData[capturePkg::packetWidth-1:capturePkg::sampleWidth];
                firstExpected = expected[capturePkg::packetWidth-1:capturePkg::sampleWidth];
            end
            gotDelta = readData[capturePkg::packetWidth-1:capturePkg::sampleWidth] - firstGot;
            expectedDelta = expected[capturePkg::packetWidth-1:capturePkg::sampleWidth]
                            - firstExpected;
            expectTrue(readData[capturePkg::sampleWidth-1:0]
                       == expected[capturePkg::sampleWidth-1:0],
                       $sformatf("%s: index %0d sample %h, expected %h", what, i,
                                 readData[capturePkg::sampleWidth-1:0],
                                 expected[capturePkg::sampleWidth-1:0]));
            if (i > 0) begin
                expectTrue(gotDelta == expectedDelta,
                           $sformatf("%s: index %0d stamp offset %0d, expected %0d", what, i,
                                     gotDelta, expectedDelta));
            end
        end
    endtask

    initial begin
        lfsrState = 32'h489a960b;
        errorCount = 0;
        timeoutCount = 0;
        reset <= 1'b1;
        sampleData <= '0;
        desiredPattern <= '0;
        activeChannels <= '0;
        dontCareChannels <= '0;
        edgeChannel <= '0;
        edgeType <= 1'b0;
        patternTriggerEnable <= 1'b0;
        edgeTriggerEnable <= 1'b0;
        maxSampleCount <= '0;
        preTriggerSampleCount <= '0;
        start <= 1'b0;
        abort <= 1'b0;
        readIndex <= '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        checkStatus(controlPkg::statusIdleBit, "after reset");
        expectTrue(storedCount == '0, "storedCount is not zero after reset");

        // A rising edge on channel 5 triggers with the pattern off and P = 12.
        @(posedge clk);
        edgeTriggerEnable <= 1'b1;
        edgeChannel <= 8'd5;
        edgeType <= 1'b1;
        maxSampleCount <= 32'd20;
        preTriggerSampleCount <= 32'd8;
        holdSample(16'h0020, 3);
        startCapture("edge capture");
        holdSample(16'h0020, 3);
        holdSample(16'h0000, 4);
        checkStatus(controlPkg::statusPreBit, "falling edge on the watched channel");
        holdSample(16'h0020, 1);
        measurePostTrigger(12, "edge capture");
        checkReadout("edge capture");

        // Channels 4 to 7 are inactive, channels 0 and 1 are don't-care and P = 10.
        @(posedge clk);
        edgeTriggerEnable <= 1'b0;
        patternTriggerEnable <= 1'b1;
        desiredPattern <= 16'hA5C3;
        activeChannels <= 16'hFF0F;
        dontCareChannels <= 16'h0003;
        maxSampleCount <= 32'd16;
        preTriggerSampleCount <= 32'd6;
        holdSample(16'hA4C3, 3);
        startCapture("pattern capture");
        holdSample(16'hA4C3, 4);
        checkStatus(controlPkg::statusPreBit, "mismatch on active channel 8");
        holdSample(16'hA530, 1);
        measurePostTrigger(10, "pattern capture");
        checkReadout("pattern capture");

        // Random data meets a rising-edge trigger on channel 15 with P = 30.
        @(posedge clk);
        patternTriggerEnable <= 1'b0;
        edgeTriggerEnable <= 1'b1;
        edgeChannel <= 8'd15;
        maxSampleCount <= 32'd40;
        preTriggerSampleCount <= 32'd10;
        startCapture("random capture");
        driveRandomUntilIdle("random capture");
        checkReadout("random capture");

        // With both triggers off only abort ends the capture.
        @(posedge clk);
        edgeTriggerEnable <= 1'b0;
        startCapture("abort in pre-trigger");
        pulseStart();
        checkStatus(controlPkg::statusPreBit, "start during pre-trigger");
        pulseAbort();
        checkStatus(controlPkg::statusIdleBit, "abort during pre-trigger");

        @(posedge clk);
        patternTriggerEnable <= 1'b1;
        activeChannels <= '0; // With an empty compare mask the pattern matches at once.
        maxSampleCount <= 32'd200;
        preTriggerSampleCount <= '0;
        startCapture("abort in post-trigger");
        waitForStatus(controlPkg::statusPostBit, "abort in post-trigger");
        pulseStart();
        checkStatus(controlPkg::statusPostBit, "start during post-trigger");
        expectTrue(storedCount != '0, "start during a capture cleared the buffer");
        pulseAbort();
        checkStatus(controlPkg::statusIdleBit, "abort during post-trigger");

        // P = 400 gives far more changes than the buffer holds.
        @(posedge clk);
        maxSampleCount <= 32'd400;
        startCapture("long capture");
        driveRandomUntilIdle("long capture");
        checkReadout("long capture");
        expectTrue(storedCount == (capturePkg::bufferAddrWidth + 1)'(capturePkg::bufferDepth),
                   "long capture did not fill the buffer");
        expectTrue(modelPackets.size() > capturePkg::bufferDepth,
                   "long capture produced too few changes");

        $display("Summary: %0d check errors, %0d timeouts", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logCapSystem.sv
`timescale 1ns/1ps
`default_nettype none

module logCapSystem (
    input  wire                                    clk,
    input  wire                                    reset,
    input  wire  [capturePkg::sampleWidth-1:0]     sampleData,
    input  wire  [capturePkg::sampleWidth-1:0]     desiredPattern,
    input  wire  [capturePkg::sampleWidth-1:0]     activeChannels,
    input  wire  [capturePkg::sampleWidth-1:0]     dontCareChannels,
    input  wire  [capturePkg::edgeSelWidth-1:0]    edgeChannel,
    input  wire                                    edgeType,
    input  wire                                    patternTriggerEnable,
    input  wire                                    edgeTriggerEnable,
    input  wire  [capturePkg::countWidth-1:0]      maxSampleCount,
    input  wire  [capturePkg::countWidth-1:0]      preTriggerSampleCount,
    input  wire                                    start,
    input  wire                                    abort,
    output logic [controlPkg::statusWidth-1:0]     status,
    input  wire  [capturePkg::bufferAddrWidth-1:0] readIndex,
    output logic [capturePkg::packetWidth-1:0]     readData,
    output logic [capturePkg::bufferAddrWidth:0]   storedCount
);

    logic [capturePkg::packetWidth-1:0] samplePacket;
    logic                               writeEnable;
    logic                               bufferClear;

    // A new capture starts from an empty buffer.
    assign bufferClear = start && status[controlPkg::statusIdleBit];

    logCap logCap_inst (
        .clk(clk),
        .reset(reset),
        .sampleData(sampleData),
        .desiredPattern(desiredPattern),
        .activeChannels(activeChannels),
        .dontCareChannels(dontCareChannels),
        .edgeChannel(edgeChannel),
        .edgeType(edgeType),
        .patternTriggerEnable(patternTriggerEnable),
        .edgeTriggerEnable(edgeTriggerEnable),
        .maxSampleCount(maxSampleCount),
        .preTriggerSampleCount(preTriggerSampleCount),
        .start(start),
        .abort(abort),
        .status(status),
        .samplePacket(samplePacket),
        .writeEnable(writeEnable),
        .sampleNumber()
    );

    captureBuffer captureBuffer_inst (
        .clk(clk),
        .reset(reset),
        .clear(bufferClear),
        .writeEnable(writeEnable),
        .writePacket(samplePacket),
        .readIndex(readIndex),
        .readData(readData),
        .storedCount(storedCount)
    );

endmodule

`default_nettype wire

// File: captureBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module captureBuffer (
    input  wire                                   clk,
    input  wire                                   reset,
    input  wire                                   clear,
    input  wire                                   writeEnable,
    input  wire  [capturePkg::packetWidth-1:0]    writePacket,
    input  wire  [capturePkg::bufferAddrWidth-1:0] readIndex,
    output logic [capturePkg::packetWidth-1:0]    readData,
    output logic [capturePkg::bufferAddrWidth:0]  storedCount
);

    logic [capturePkg::packetWidth-1:0] packetMem [capturePkg::bufferDepth];

    logic [capturePkg::bufferAddrWidth-1:0] writePtr;
    logic [capturePkg::bufferAddrWidth-1:0] oldestPtr;
    logic [capturePkg::bufferAddrWidth-1:0] readAddr;
    logic                                   bufferFull;

    assign bufferFull = storedCount == (capturePkg::bufferAddrWidth + 1)'(capturePkg::bufferDepth);

    // When full the count wraps to zero in its low bits, so oldest equals writePtr.
    assign oldestPtr = writePtr - storedCount[capturePkg::bufferAddrWidth-1:0];
    assign readAddr  = oldestPtr + readIndex;

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            writePtr    <= '0;
            storedCount <= '0;
        end else if (writeEnable) begin
            writePtr <= writePtr + 1'b1;
            if (!bufferFull) begin
                storedCount <= storedCount + 1'b1;
            end
        end
    end

    // The oldest entry is overwritten once the buffer is full.
    always_ff @(posedge clk) begin
        if (writeEnable && !clear) begin
            packetMem[writePtr] <= writePacket;
        end
    end

    always_ff @(posedge clk) begin
        readData <= packetMem[readAddr];
    end

endmodule

`default_nettype wire

// File: logCap.sv
`timescale 1ns/1ps
`default_nettype none

module logCap (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire  [capturePkg::sampleWidth-1:0]  sampleData,
    input  wire  [capturePkg::sampleWidth-1:0]  desiredPattern,
    input  wire  [capturePkg::sampleWidth-1:0]  activeChannels,
    input  wire  [capturePkg::sampleWidth-1:0]  dontCareChannels,
    input  wire  [capturePkg::edgeSelWidth-1:0] edgeChannel,
    input  wire                                 edgeType,
    input  wire                                 patternTriggerEnable,
    input  wire                                 edgeTriggerEnable,
    input  wire  [capturePkg::countWidth-1:0]   maxSampleCount,
    input  wire  [capturePkg::countWidth-1:0]   preTriggerSampleCount,
    input  wire                                 start,
    input  wire                                 abort,
    output logic [controlPkg::statusWidth-1:0]  status,
    output logic [capturePkg::packetWidth-1:0]  samplePacket,
    output logic                                writeEnable,
    output logic [capturePkg::countWidth-1:0]   sampleNumber
);

    logic [capturePkg::sampleWidth-1:0] latestSample;
    logic [capturePkg::sampleWidth-1:0] previousSample;
    logic [capturePkg::countWidth-1:0]  triggerSampleNumber;
    logic [capturePkg::countWidth-1:0]  postTriggerSamples;
    logic                               triggered;
    logic                               transition;
    logic                               complete;
    logic                               idle;
    logic                               preTrigger;
    logic                               postTrigger;
    logic                               running;

    always_ff @(posedge clk) begin
        if (reset) begin
            latestSample   <= '0;
            previousSample <= '0;
        end else begin
            latestSample   <= sampleData;
            previousSample <= latestSample;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            triggerSampleNumber <= '0;
        end else if (triggered && preTrigger) begin
            triggerSampleNumber <= sampleNumber;
        end
    end

    // The post-trigger window is whatever remains after the pre-trigger share.
    assign postTriggerSamples = maxSampleCount - preTriggerSampleCount;
    assign complete = (sampleNumber - triggerSampleNumber) >= postTriggerSamples;
    assign running  = preTrigger || postTrigger;

    always_comb begin
        status = '0;
        status[controlPkg::statusIdleBit] = idle;
        status[controlPkg::statusPreBit]  = preTrigger;
        status[controlPkg::statusPostBit] = postTrigger;
    end

    triggerTransDetection triggerDetect (
        .latestSample(latestSample),
        .previousSample(previousSample),
        .desiredPattern(desiredPattern),
        .activeChannels(activeChannels),
        .dontCareChannels(dontCareChannels),
        .edgeChannel(edgeChannel),
        .edgeType(edgeType),
        .patternTriggerEnabled(patternTriggerEnable),
        .edgeTriggerEnabled(edgeTriggerEnable),
        .triggered(triggered),
        .transition(transition)
    );

    analyzerControlFsm controlFsm (
        .clk(clk),
        .reset(reset),
        .start(start),
        .abort(abort),
        .sawTrigger(triggered),
        .complete(complete),
        .idle(idle),
        .preTrigger(preTrigger),
        .postTrigger(postTrigger)
    );

    sampleGen packetGen (
        .clk(clk),
        .reset(reset),
        .running(running),
        .transition(transition),
        .sampleData(latestSample),
        .sampleNumber(sampleNumber),
        .samplePacket(samplePacket),
        .writeEnable(writeEnable)
    );

endmodule

`default_nettype wire

// File: sampleGen.sv
`timescale 1ns/1ps
`default_nettype none

module sampleGen (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire                                 running,
    input  wire                                 transition,
    input  wire  [capturePkg::sampleWidth-1:0]  sampleData,
    output logic [capturePkg::countWidth-1:0]   sampleNumber,
    output logic [capturePkg::packetWidth-1:0]  samplePacket,
    output logic                                writeEnable
);

    logic firstWritten;
    logic packetDue;

    // A run always opens with one packet and then records only changes.
    assign packetDue = running && (!firstWritten || transition);

    always_ff @(posedge clk) begin
        if (reset) begin
            sampleNumber <= '0;
            firstWritten <= 1'b0;
        end else if (running) begin
            sampleNumber <= sampleNumber + 1'b1;
            firstWritten <= 1'b1;
        end else begin
            sampleNumber <= '0;
            firstWritten <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            writeEnable <= 1'b0;
        end else begin
            writeEnable <= packetDue;
        end
    end

    // The stamp fills the upper half and the sample value the lower half.
    always_ff @(posedge clk) begin
        if (packetDue) begin
            samplePacket <= {sampleNumber[capturePkg::stampWidth-1:0], sampleData};
        end
    end

endmodule

`default_nettype wire

// File: analyzerControlFsm.sv
`timescale 1ns/1ps
`default_nettype none

module analyzerControlFsm (
    input  wire  clk,
    input  wire  reset,
    input  wire  start,
    input  wire  abort,
    input  wire  sawTrigger,
    input  wire  complete,
    output logic idle,
    output logic preTrigger,
    output logic postTrigger
);

    controlPkg::captureState state;
    controlPkg::captureState nextState;

    always_comb begin
        nextState = state;
        if (abort) begin
            nextState = controlPkg::stateIdle; // Abort wins over every other event.
        end else begin
            case (state)
                controlPkg::stateIdle: begin
                    if (start) begin
                        nextState = controlPkg::statePreTrigger;
                    end
                end
                controlPkg::statePreTrigger: begin
                    if (sawTrigger) begin
                        nextState = controlPkg::statePostTrigger;
                    end
                end
                controlPkg::statePostTrigger: begin
                    if (complete) begin
                        nextState = controlPkg::stateIdle;
                    end
                end
                default: begin
                    nextState = controlPkg::stateIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= controlPkg::stateIdle;
        end else begin
            state <= nextState;
        end
    end

    // One-hot decode of the state register.
    assign idle        = state == controlPkg::stateIdle;
    assign preTrigger  = state == controlPkg::statePreTrigger;
    assign postTrigger = state == controlPkg::statePostTrigger;

endmodule

`default_nettype wire

// File: triggerTransDetection.sv
`timescale 1ns/1ps
`default_nettype none

module triggerTransDetection (
    input  wire [capturePkg::sampleWidth-1:0]  latestSample,
    input  wire [capturePkg::sampleWidth-1:0]  previousSample,
    input  wire [capturePkg::sampleWidth-1:0]  desiredPattern,
    input  wire [capturePkg::sampleWidth-1:0]  activeChannels,
    input  wire [capturePkg::sampleWidth-1:0]  dontCareChannels,
    input  wire [capturePkg::edgeSelWidth-1:0] edgeChannel,
    input  wire                                edgeType,
    input  wire                                patternTriggerEnabled,
    input  wire                                edgeTriggerEnabled,
    output logic                               triggered,
    output logic                               transition
);

    logic [capturePkg::sampleWidth-1:0] compareMask;
    logic [capturePkg::sampleWidth-1:0] latestShifted;
    logic [capturePkg::sampleWidth-1:0] previousShifted;
    logic                               patternMatch;
    logic                               channelInRange;
    logic                               latestBit;
    logic                               previousBit;
    logic                               edgeSeen;

    // Only channels that are active and not don't-care take part in the compare.
    assign compareMask  = activeChannels & ~dontCareChannels;
    assign patternMatch = ((latestSample ^ desiredPattern) & compareMask) == '0;

    // Select the watched channel by shifting it down to bit 0.
    assign channelInRange  = edgeChannel < capturePkg::edgeSelWidth'(capturePkg::sampleWidth);
    assign latestShifted   = latestSample >> edgeChannel;
    assign previousShifted = previousSample >> edgeChannel;
    assign latestBit       = latestShifted[0];
    assign previousBit     = previousShifted[0];

    always_comb begin
        if (!channelInRange) begin
            edgeSeen = 1'b0; // A channel past the bus never fires.
        end else if (edgeType) begin
            edgeSeen = !previousBit && latestBit;
        end else begin
            edgeSeen = previousBit && !latestBit;
        end
    end

    assign triggered = (patternTriggerEnabled && patternMatch) ||
                       (edgeTriggerEnabled && edgeSeen);

    assign transition = latestSample != previousSample;

endmodule

`default_nettype wire

// File: controlPkg.sv
`default_nettype none

package controlPkg;

    typedef enum logic [1:0] {
        stateIdle        = 2'd0,
        statePreTrigger  = 2'd1,
        statePostTrigger = 2'd2
    } captureState;

    // The status word keeps its unused upper bits at zero.
    localparam int statusWidth = 8;
    localparam int statusIdleBit = 0;
    localparam int statusPreBit = 1;
    localparam int statusPostBit = 2;

endpackage

`default_nettype wire

// File: capturePkg.sv
`default_nettype none

package capturePkg;

    // Input channels captured on every clock.
    localparam int sampleWidth = 16;

    // One packet carries a stamp in the upper half and the sample in the lower half.
    localparam int packetWidth = 32;
    localparam int stampWidth = packetWidth - sampleWidth;

    // Sample counters and the count settings share one width.
    localparam int countWidth = 32;

    // Index of the channel watched for an edge.
    localparam int edgeSelWidth = 8;

    // Capture buffer geometry.
    localparam int bufferDepth = 64;
    localparam int bufferAddrWidth = $clog2(bufferDepth);

endpackage

`default_nettype wire
